// File: Bender.yml
package:
  name: board_audio_meter

export_include_dirs:
  - include

sources:
  - src/meter_pkg.sv
  - src/stream_if.sv
  - src/i2s_mic_receiver.sv
  - src/stream_skid.sv
  - src/peak_meter.sv
  - src/level_to_segments.sv
  - src/tm1638_shifter.sv
  - src/board_audio_top.sv
  - target: test
    files:
      - bench/board_models.sv
      - bench/tb_board_audio_top.sv

// File: bench/board_models.sv
`include "meter_defines.svh"

module i2s_mic_model (
    input  logic clk,
    input  logic rst,
    input  logic sck,
    input  logic ws,
    output logic sd
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [`W_SAMPLE - 1:0] words [$];          // Left words waiting to be played.
    bit                     window_real [$];    // One entry per window, set if it played words.
    logic [`W_SAMPLE - 1:0] window_words [`PEAK_WINDOW];
    logic [`W_SAMPLE - 1:0] cur_word;
    logic                   sd_q = 1'b0;
    logic                   sck_q;
    logic                   ws_q;
    logic                   fresh;
    int                     pos;                // Bit position within the current slot.
    int                     frame_idx;

    assign sd = sd_q;

    // A window only plays queued words when all of them are there.
    task automatic begin_frame();
        bit take;
        if (frame_idx % `PEAK_WINDOW == 0)
        begin
            take = (words.size() >= `PEAK_WINDOW);
            for (int i = 0; i < `PEAK_WINDOW; i++)
            begin
                if (take)
                    window_words[i] = words.pop_front();
                else
                    window_words[i] = '0;
            end
            window_real.push_back(take);
        end
        cur_word  = window_words[frame_idx % `PEAK_WINDOW];
        frame_idx = frame_idx + 1;
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            sck_q     = 1'b0;
            ws_q      = 1'b0;
            fresh     = 1'b1;
            pos       = 0;
            frame_idx = 0;
            sd_q     <= 1'b0;
        end
        else
        begin
            if (fresh)
            begin
                begin_frame();    // The first left slot opens as reset is released.
                fresh = 1'b0;
            end
            if (sck_q && !sck)
            begin
                if (ws != ws_q)
                begin
                    pos = 0;
                    if (!ws)
                        begin_frame();
                end
                else
                    pos = pos + 1;
                ws_q = ws;
                if (!ws && pos >= 1 && pos <= `W_SAMPLE)
                    sd_q <= cur_word[`W_SAMPLE - pos];    // MSB follows the delay bit.
                else
                    sd_q <= 1'b0;                         // Right slot stays silent.
            end
            sck_q = sck;
        end
    end

endmodule

module tm1638_monitor (
    input logic clk,
    input logic rst,
    input logic sio_clk,
    input logic sio_stb,
    input logic sio_data
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] bytes_seen [$];
    int         frame_len [$];    // Bytes in each strobe period, in arrival order.
    logic [7:0] shift_q;
    logic       clk_q;
    logic       stb_q;
    int         bit_cnt;
    int         byte_cnt;

    always @(posedge clk)
    begin
        if (rst)
        begin
            clk_q    = 1'b1;
            stb_q    = 1'b1;
            bit_cnt  = 0;
            byte_cnt = 0;
        end
        else
        begin
            if (stb_q && !sio_stb)
            begin
                bit_cnt  = 0;
                byte_cnt = 0;
            end
            if (!clk_q && sio_clk && !sio_stb)
            begin
                shift_q = {sio_data, shift_q[7:1]};    // LSB arrives first.
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 8)
                begin
                    bytes_seen.push_back(shift_q);
                    byte_cnt = byte_cnt + 1;
                    bit_cnt  = 0;
                end
            end
            if (!stb_q && sio_stb)
                frame_len.push_back(byte_cnt);
            clk_q = sio_clk;
            stb_q = sio_stb;
        end
    end

endmodule

// File: bench/tb_board_audio_top.sv
`include "meter_defines.svh"

module tb_board_audio_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int window_cycles = `PEAK_WINDOW * 64 * `SCK_DIV;
    localparam int n_blank       = `N_DIGITS - `W_SAMPLE / 4;

    // Segment patterns for 0 to F, segment a in the MSB.
    localparam logic [7:0] hex_font [16] = '{
        8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0,
        8'hFE, 8'hF6, 8'hEE, 8'h3E, 8'h9C, 8'h7A, 8'h9E, 8'h8E
    };

    logic        clk;
    logic        rst;
    logic        mic_sck;
    logic        mic_ws;
    logic        mic_sd;
    logic        sio_clk;
    logic        sio_stb;
    logic        sio_data;
    logic [31:0] lfsr_state;

    board_audio_top DUT (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mic_sd   ( mic_sd   ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_data ( sio_data )
    );

    i2s_mic_model i_mic_model (
        .clk ( clk     ),
        .rst ( rst     ),
        .sck ( mic_sck ),
        .ws  ( mic_ws  ),
        .sd  ( mic_sd  )
    );

    tm1638_monitor i_display_model (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_data ( sio_data )
    );

    always #2 clk = ~clk;

    // Taps 32, 22, 2 and 1.
    function automatic logic next_random_bit();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [`W_SAMPLE - 1:0] random_word();
        logic [`W_SAMPLE - 1:0] word;
        word = '0;
        for (int i = 0; i < `W_SAMPLE; i++)
            word = {word[`W_SAMPLE - 2:0], next_random_bit()};
        return word;
    endfunction

    function automatic logic [`W_SAMPLE - 1:0] magnitude(input logic [`W_SAMPLE - 1:0] word);
        if (word[`W_SAMPLE - 1])
            return ~word + 1'b1;
        return word;
    endfunction

    function automatic logic [7:0] reverse_byte(input logic [7:0] value);
        logic [7:0] result;
        for (int i = 0; i < 8; i++)
            result[i] = value[7 - i];
        return result;
    endfunction

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped after an error.");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("FAILED at %0t ns: %s, got 'h%0h, expected 'h%0h",
                     $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "Simulation stopped at the first mismatch.");
        end
    endtask

    task automatic wait_for_frame();
        int waited;
        waited = 0;
        while (i_display_model.frame_len.size() == 0)
        begin
            if (waited == 3 * window_cycles)
                stop_with_error("Timed out waiting for a display frame.");
            @(negedge clk);
            waited = waited + 1;
        end
    endtask

    // Checks the byte layout of one frame and decodes the value it shows.
    task automatic read_frame(output logic [`W_SAMPLE - 1:0] shown);
        logic [7:0] frame [1 + `N_DIGITS];
        logic [7:0] pattern;
        int         len;
        bit         found;
        wait_for_frame();
        len = i_display_model.frame_len.pop_front();
        check_value(len, 1 + `N_DIGITS, "bytes in a display frame");
        for (int i = 0; i <= `N_DIGITS; i++)
            frame[i] = i_display_model.bytes_seen.pop_front();
        check_value(frame[0], `TM_ADDR_CMD, "address command byte");
        for (int i = 1; i <= n_blank; i++)
            check_value(frame[i], 8'h00, "blank leading digit");
        shown = '0;
        for (int i = n_blank + 1; i <= `N_DIGITS; i++)
        begin
            pattern = reverse_byte(frame[i]);
            found   = 1'b0;
            for (int n = 0; n < 16; n++)
            begin
                if (hex_font[n] == pattern)
                begin
                    shown = {shown[`W_SAMPLE - 5:0], 4'(n)};
                    found = 1'b1;
                end
            end
            if (!found)
                stop_with_error("A digit byte on the display is not a hex font pattern.");
        end
    endtask

    // Silent windows between tests must show zero and are skipped.
    task automatic next_window_level(output logic [`W_SAMPLE - 1:0] shown);
        bit real_window;
        int silent;
        real_window = 1'b0;
        silent      = 0;
        while (!real_window)
        begin
            if (silent == 4)
                stop_with_error("Queued microphone words never reached the display.");
            read_frame(shown);
            if (i_mic_model.window_real.size() == 0)
                stop_with_error("A display frame arrived for a window that was never played.");
            real_window = i_mic_model.window_real.pop_front();
            if (!real_window)
            begin
                check_value(shown, 0, "level of a silent window");
                silent = silent + 1;
            end
        end
    endtask

    task automatic push_window(input logic [`W_SAMPLE - 1:0] words [`PEAK_WINDOW],
                               output logic [`W_SAMPLE - 1:0] peak);
        peak = '0;
        for (int i = 0; i < `PEAK_WINDOW; i++)
        begin
            i_mic_model.words.push_back(words[i]);
            if (magnitude(words[i]) > peak)
                peak = magnitude(words[i]);
        end
    endtask

    task automatic expect_reset_state();
        @(negedge clk);
        check_value(sio_stb, 1'b1, "sio_stb after reset");
        check_value(sio_clk, 1'b1, "sio_clk after reset");
        check_value(sio_data, 1'b0, "sio_data after reset");
        check_value(mic_sck, 1'b0, "mic_sck after reset");
        check_value(mic_ws, 1'b0, "mic_ws after reset");
        repeat (48 * `SCK_DIV) @(negedge clk);    // Middle of the first right slot.
        check_value(mic_ws, 1'b1, "mic_ws in the right slot");
        // Just short of the first window.
        repeat (window_cycles - 64 - 48 * `SCK_DIV) @(negedge clk);
        check_value(i_display_model.frame_len.size(), 0, "frames before the first window");
        check_value(sio_stb, 1'b1, "sio_stb before the first window");
    endtask

    task automatic show_constant_level();
        logic [`W_SAMPLE - 1:0] words [`PEAK_WINDOW];
        logic [`W_SAMPLE - 1:0] values [2];
        logic [`W_SAMPLE - 1:0] peak;
        logic [`W_SAMPLE - 1:0] shown;
        values[0] = 24'h3A5C17;
        values[1] = 24'h7FFFFF;
        for (int v = 0; v < 2; v++)
        begin
            for (int i = 0; i < `PEAK_WINDOW; i++)
                words[i] = values[v];
            push_window(words, peak);
            next_window_level(shown);
            check_value(shown, values[v], "level of a constant window");
        end
    endtask

    task automatic find_signed_peak();
        logic [`W_SAMPLE - 1:0] words [`PEAK_WINDOW];
        logic [`W_SAMPLE - 1:0] peak;
        logic [`W_SAMPLE - 1:0] shown;
        for (int w = 0; w < 2; w++)
        begin
            for (int i = 0; i < `PEAK_WINDOW; i++)
                words[i] = random_word();
            words[0][`W_SAMPLE - 1] = 1'b1;    // At least one negative word.
            words[1][`W_SAMPLE - 1] = 1'b0;
            if (w == 1)
                words[2] = 24'h800000;
            push_window(words, peak);
            next_window_level(shown);
            check_value(shown, peak, "peak of a signed window");
        end
    endtask

    task automatic clear_between_windows();
        logic [`W_SAMPLE - 1:0] words [`PEAK_WINDOW];
        logic [`W_SAMPLE - 1:0] peak_large;
        logic [`W_SAMPLE - 1:0] peak_small;
        logic [`W_SAMPLE - 1:0] shown;
        words = '{24'h000010, 24'h7F0000, 24'hFFFFF0, 24'h000003};
        push_window(words, peak_large);
        words = '{24'h000123, 24'hFFFF00, 24'h000045, 24'h000002};
        push_window(words, peak_small);
        next_window_level(shown);
        check_value(shown, peak_large, "peak of the large window");
        next_window_level(shown);
        check_value(shown, peak_small, "peak of the small window that follows");
    endtask

    task automatic stream_many_windows();
        logic [`W_SAMPLE - 1:0] words [`PEAK_WINDOW];
        logic [`W_SAMPLE - 1:0] expected [$];
        logic [`W_SAMPLE - 1:0] peak;
        logic [`W_SAMPLE - 1:0] shown;
        for (int w = 0; w < 20; w++)
        begin
            for (int i = 0; i < `PEAK_WINDOW; i++)
                words[i] = random_word();
            push_window(words, peak);
            expected.push_back(peak);
        end
        for (int w = 0; w < 20; w++)
        begin
            next_window_level(shown);
            check_value(shown, expected.pop_front(), "peak in a sustained stream");
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        lfsr_state = 32'h3275;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        expect_reset_state();
        show_constant_level();
        find_signed_peak();
        clear_between_windows();
        stream_many_windows();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: include/meter_defines.svh
`ifndef METER_DEFINES_SVH
`define METER_DEFINES_SVH

// Width of one microphone word.
`define W_SAMPLE      24

// System clock cycles per I2S sck period, half low and half high.
`define SCK_DIV       8

// System clock cycles per half period of the TM1638 serial clock.
`define SIO_DIV       4

// Stereo frames that make up one peak window.
`define PEAK_WINDOW   4

`define N_DIGITS      8          // Digits per display frame.
`define TM_ADDR_CMD   8'hC0      // Address-set command sent ahead of the digits.

`endif

// File: src.f
+incdir+include
src/meter_pkg.sv
src/stream_if.sv
src/i2s_mic_receiver.sv
src/stream_skid.sv
src/peak_meter.sv
src/level_to_segments.sv
src/tm1638_shifter.sv
src/board_audio_top.sv
bench/board_models.sv
bench/tb_board_audio_top.sv

// File: src/board_audio_top.sv
module board_audio_top (
    input  logic clk,
    input  logic rst,
    output logic mic_sck,
    output logic mic_ws,
    input  logic mic_sd,
    output logic sio_clk,
    output logic sio_stb,
    output logic sio_data
);

    stream_if #(.payload_t(meter_pkg::sample_t)) rx_s  ();
    stream_if #(.payload_t(meter_pkg::sample_t)) smp_s ();
    stream_if #(.payload_t(meter_pkg::level_t))  lvl_s ();
    stream_if #(.payload_t(meter_pkg::seg_t))    dig_s ();
    stream_if #(.payload_t(meter_pkg::seg_t))    seg_s ();

    i2s_mic_receiver i_microphone (
        .clk ( clk     ),
        .rst ( rst     ),
        .sck ( mic_sck ),
        .ws  ( mic_ws  ),
        .sd  ( mic_sd  ),
        .out ( rx_s    )
    );

    stream_skid #(.payload_t(meter_pkg::sample_t)) i_sample_skid (
        .clk ( clk   ),
        .rst ( rst   ),
        .in  ( rx_s  ),
        .out ( smp_s )
    );

    peak_meter i_peak (
        .clk ( clk   ),
        .rst ( rst   ),
        .in  ( smp_s ),
        .out ( lvl_s )
    );

    level_to_segments i_segments (
        .clk ( clk   ),
        .rst ( rst   ),
        .in  ( lvl_s ),
        .out ( dig_s )
    );

    // Keeps the digit sequence moving while the shifter is mid-byte.
    stream_skid #(.payload_t(meter_pkg::seg_t)) i_digit_skid (
        .clk ( clk   ),
        .rst ( rst   ),
        .in  ( dig_s ),
        .out ( seg_s )
    );

    tm1638_shifter i_tm1638 (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .in       ( seg_s    ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_data ( sio_data )
    );

endmodule

// File: src/i2s_mic_receiver.sv
`include "meter_defines.svh"

module i2s_mic_receiver (
    input  logic     clk,
    input  logic     rst,
    output logic     sck,
    output logic     ws,
    input  logic     sd,
    stream_if.source out
);

    localparam int div_w = $clog2(`SCK_DIV);
    localparam int half  = `SCK_DIV / 2;

    logic [div_w - 1:0]     div_cnt;
    logic [5:0]             bit_cnt;     // Position within the 64-bit stereo frame.
    logic [`W_SAMPLE - 2:0] shift_q;     // All bits of the word except the last.
    logic                   rise_tick;
    logic                   fall_tick;
    logic                   take_bit;
    logic                   word_done;

    assign rise_tick = (div_cnt == div_w'(half - 1));
    assign fall_tick = (div_cnt == div_w'(`SCK_DIV - 1));

    // Slot position 0 is the delay bit that follows every ws edge.
    assign take_bit  = rise_tick && (bit_cnt[4:0] != 5'd0)
                     && (bit_cnt[4:0] < 5'(`W_SAMPLE));
    assign word_done = rise_tick && (bit_cnt[4:0] == 5'(`W_SAMPLE));

    assign ws = bit_cnt[5];    // Low for the left slot, high for the right one.

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            div_cnt   <= '0;
            bit_cnt   <= '0;
            sck       <= 1'b0;
            out.valid <= 1'b0;
        end
        else
        begin
            div_cnt <= fall_tick ? '0 : div_cnt + 1'b1;

            if (rise_tick)
                sck <= 1'b1;
            else if (fall_tick)
            begin
                sck     <= 1'b0;
                bit_cnt <= bit_cnt + 1'b1;    // Wraps after the right slot.
            end

            if (out.valid && out.ready)
                out.valid <= 1'b0;
            if (word_done)
                out.valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take_bit)
            shift_q <= {shift_q[`W_SAMPLE - 3:0], sd};    // MSB arrives first.
        if (word_done)
        begin
            out.data <= meter_pkg::sample_t'({shift_q, sd});
            out.last <= ws;    // The right word closes the stereo frame.
        end
    end

    // There is no overrun handling, so the pipeline must take each word
    // within one slot.
    a_no_overrun : assert property (
        @(posedge clk) disable iff (rst)
        word_done |-> !out.valid || out.ready
    ) else $error("Microphone word completed before the previous one was taken.");

endmodule

// File: src/level_to_segments.sv
`include "meter_defines.svh"

module level_to_segments (
    input  logic     clk,
    input  logic     rst,
    stream_if.sink   in,
    stream_if.source out
);

    localparam int idx_w = $clog2(`N_DIGITS);
    localparam int n_hex = `W_SAMPLE / 4;    // Digits that carry a nibble.

    meter_pkg::level_t  level_q;
    meter_pkg::level_t  shifted;
    logic [idx_w - 1:0] digit_idx;    // Digit on the output, counts down to 0.
    logic               busy;

    function automatic meter_pkg::seg_t hex_font(input logic [3:0] nibble);
        case (nibble)
            4'h0: hex_font = 8'hFC;
            4'h1: hex_font = 8'h60;
            4'h2: hex_font = 8'hDA;
            4'h3: hex_font = 8'hF2;
            4'h4: hex_font = 8'h66;
            4'h5: hex_font = 8'hB6;
            4'h6: hex_font = 8'hBE;
            4'h7: hex_font = 8'hE0;
            4'h8: hex_font = 8'hFE;
            4'h9: hex_font = 8'hF6;
            4'hA: hex_font = 8'hEE;
            4'hB: hex_font = 8'h3E;
            4'hC: hex_font = 8'h9C;
            4'hD: hex_font = 8'h7A;
            4'hE: hex_font = 8'h9E;
            default: hex_font = 8'h8E;
        endcase
    endfunction

    assign shifted   = level_q >> (4 * digit_idx);
    assign in.ready  = !busy;
    assign out.valid = busy;
    assign out.last  = (digit_idx == '0);
    assign out.data  = (digit_idx >= idx_w'(n_hex)) ? 8'h00 : hex_font(shifted[3:0]);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy      <= 1'b0;
            digit_idx <= '0;
        end
        else if (in.valid && in.ready)
        begin
            busy      <= 1'b1;
            digit_idx <= idx_w'(`N_DIGITS - 1);    // Leftmost digit goes first.
        end
        else if (out.valid && out.ready)
        begin
            if (digit_idx == '0)
                busy <= 1'b0;
            else
                digit_idx <= digit_idx - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in.valid && in.ready)
            level_q <= in.data;
    end

endmodule

// File: src/meter_pkg.sv
`include "meter_defines.svh"

package meter_pkg;

    // Raw two's complement word as it leaves the microphone.
    typedef logic signed [`W_SAMPLE - 1:0] sample_t;

    // Magnitude of a sample. One extra code is needed for the most negative
    // word, which maps to the MSB alone.
    typedef logic        [`W_SAMPLE - 1:0] level_t;

    // Seven-segment pattern, segment a in the MSB and the point in the LSB.
    typedef logic        [7:0]             seg_t;

endpackage

// File: src/peak_meter.sv
`include "meter_defines.svh"

module peak_meter (
    input  logic     clk,
    input  logic     rst,
    stream_if.sink   in,
    stream_if.source out
);

    localparam int cnt_w = (`PEAK_WINDOW > 1) ? $clog2(`PEAK_WINDOW) : 1;

    meter_pkg::level_t  max_q;        // Running maximum of the current window.
    meter_pkg::level_t  mag;
    meter_pkg::level_t  peak_next;
    logic [cnt_w - 1:0] frame_cnt;
    logic               accept;
    logic               window_end;

    // Negating the most negative word gives 24'h800000, read as unsigned.
    assign mag = in.data[`W_SAMPLE - 1] ? meter_pkg::level_t'(-in.data)
                                        : meter_pkg::level_t'(in.data);

    assign peak_next  = (mag > max_q) ? mag : max_q;
    assign in.ready   = !out.valid || out.ready;
    assign accept     = in.valid && in.ready;
    assign window_end = accept && in.last && (frame_cnt == cnt_w'(`PEAK_WINDOW - 1));

    assign out.last = 1'b1;    // Each level is a frame of its own.

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            max_q     <= '0;
            frame_cnt <= '0;
            out.valid <= 1'b0;
        end
        else
        begin
            if (out.valid && out.ready)
                out.valid <= 1'b0;

            if (window_end)
            begin
                out.valid <= 1'b1;
                out.data  <= peak_next;
                max_q     <= '0;
                frame_cnt <= '0;
            end
            else if (accept)
            begin
                max_q <= peak_next;
                if (in.last)
                    frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    // The display path must take a level long before the next frame's
    // samples show up, otherwise the microphone stalls.
    a_display_keeps_up : assert property (
        @(posedge clk) disable iff (rst)
        out.valid && !out.ready |-> !in.valid
    ) else $error("Display path still busy when the next sample arrived.");

endmodule

// File: src/stream_if.sv
interface stream_if #(
    parameter type payload_t = logic
);

    logic     valid;    // Item on data is offered.
    logic     ready;    // Sink can take the item this cycle.
    payload_t data;
    logic     last;     // Closes a group of items.

    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

// File: src/stream_skid.sv
module stream_skid #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    stream_if.sink   in,
    stream_if.source out
);

    payload_t skid_data;
    logic     skid_last;
    logic     skid_valid;    // Second entry in use.
    logic     out_free;

    assign out_free = !out.valid || out.ready;
    assign in.ready = !skid_valid;    // Registered, so no combinational path upstream.

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out.valid  <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (out_free)
        begin
            out.valid  <= skid_valid || in.valid;
            skid_valid <= 1'b0;
        end
        else if (in.valid && in.ready)
            skid_valid <= 1'b1;    // The output is stalled, so the new item waits here.
    end

    always_ff @(posedge clk)
    begin
        if (out_free)
        begin
            out.data <= skid_valid ? skid_data : in.data;    // Older item leaves first.
            out.last <= skid_valid ? skid_last : in.last;
        end
        if (!out_free && !skid_valid)
        begin
            skid_data <= in.data;
            skid_last <= in.last;
        end
    end

    // With both entries occupied the buffer has no room, so a refused item
    // has to wait at the input until it is taken.
    a_no_overfill : assert property (
        @(posedge clk) disable iff (rst)
        in.valid && !in.ready |=> in.valid && $stable(in.data)
    ) else $error("Item withdrawn while the skid buffer was full.");

endmodule

// File: src/tm1638_shifter.sv
`include "meter_defines.svh"

module tm1638_shifter (
    input  logic   clk,
    input  logic   rst,
    stream_if.sink in,
    output logic   sio_clk,
    output logic   sio_stb,
    output logic   sio_data
);

    localparam int div_w = (`SIO_DIV > 1) ? $clog2(`SIO_DIV) : 1;

    typedef enum logic [1:0] {st_idle, st_cmd, st_data, st_gap} state_t;

    state_t             state;
    logic [div_w - 1:0] div_cnt;
    logic [2:0]         bit_cnt;
    logic [7:0]         shift_q;
    logic [7:0]         start_byte;
    logic               shifting;     // A byte is on the wire.
    logic               phase;        // Second half of a bit, sio_clk high.
    logic               last_q;
    logic               half_tick;
    logic               start;
    logic               byte_done;

    // The display takes bytes LSB first, so the pattern is mirrored to send a first.
    function automatic logic [7:0] mirror(input meter_pkg::seg_t abcdefgh);
        for (int i = 0; i < 8; i++)
            mirror[i] = abcdefgh[7 - i];
    endfunction

    assign half_tick  = (div_cnt == div_w'(`SIO_DIV - 1));
    assign in.ready   = (state == st_data) && !shifting;
    assign start      = ((state == st_idle) && in.valid) || (in.valid && in.ready);
    assign start_byte = (state == st_idle) ? `TM_ADDR_CMD : mirror(in.data);
    assign byte_done  = shifting && half_tick && phase && (bit_cnt == 3'd7);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= st_idle;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            shift_q  <= '0;
            shifting <= 1'b0;
            phase    <= 1'b0;
            last_q   <= 1'b0;
            sio_clk  <= 1'b1;
            sio_stb  <= 1'b1;
            sio_data <= 1'b0;
        end
        else
        begin
            div_cnt <= half_tick ? '0 : div_cnt + 1'b1;

            if (shifting && half_tick)
            begin
                phase <= !phase;
                if (!phase)
                    sio_clk <= 1'b1;    // Display samples on this edge.
                else if (bit_cnt != 3'd7)
                begin
                    sio_clk  <= 1'b0;
                    sio_data <= shift_q[1];
                    shift_q  <= shift_q >> 1;
                    bit_cnt  <= bit_cnt + 1'b1;
                end
            end

            if (byte_done)
            begin
                shifting <= 1'b0;
                if (state == st_cmd)
                    state <= st_data;
                else if (last_q)
                begin
                    state    <= st_gap;
                    sio_stb  <= 1'b1;
                    sio_data <= 1'b0;
                end
            end

            if (state == st_gap && half_tick)
            begin
                phase <= !phase;
                if (phase)
                    state <= st_idle;    // Strobe has been high for two half periods.
            end

            if (start)
            begin
                if (state == st_idle)
                begin
                    state   <= st_cmd;
                    sio_stb <= 1'b0;
                end
                else
                    last_q <= in.last;
                shift_q  <= start_byte;
                sio_data <= start_byte[0];
                sio_clk  <= 1'b0;
                div_cnt  <= '0;
                bit_cnt  <= '0;
                phase    <= 1'b0;
                shifting <= 1'b1;
            end
        end
    end

    // Each bit starts with a falling sio_clk and lasts two half periods,
    // so the strobe must cover that whole span.
    a_stb_covers_byte : assert property (
        @(posedge clk) disable iff (rst)
        $fell(sio_clk) |-> !sio_stb [* 2 * `SIO_DIV]
    ) else $error("sio_stb rose in the middle of a byte.");

endmodule
